/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_fetch -f tb.f -o tb_fetch_sim
./obj_dir/tb_fetch_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended early"
    exit 1
fi
echo "simulation passed"

/* source/fetch_bip.sv */
`timescale 1ns/1ns
`include "fetch_macros.svh"

module fetch_bip (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`FETCH_LEN_W-1:0] d_length,
    input  logic                    stall,
    input  logic                    is_resteer,
    input  logic                    is_br_taken,
    input  logic                    is_init,
    input  logic                    packet_out_valid,
    input  logic [`FETCH_BIP_W-1:0] wb_bip,
    input  logic [`FETCH_BIP_W-1:0] bp_bip,
    input  logic [`FETCH_BIP_W-1:0] init_bip,
    output logic [`FETCH_BIP_W-1:0] old_bip,
    output logic [`FETCH_BIP_W-1:0] new_bip,
    output logic                    flush,
    output logic                    free_strobe,
    output logic [1:0]              free_line
);

    fetch_pkg::cf_src_e      cf_src;
    logic [`FETCH_LEN_W-1:0] bip_sum;
    logic [`FETCH_BIP_W-1:0] bip_d;
    logic                    adv_ok;
    logic                    ld_bip;
    logic                    seq_ld;

    // length add wraps around the 64-byte window
    assign bip_sum = {{(`FETCH_LEN_W-`FETCH_BIP_W){1'b0}}, old_bip} + d_length;
    assign new_bip = bip_sum[`FETCH_BIP_W-1:0];

    // init first, then writeback, then predictor
    always_comb begin
        if (is_init) begin
            cf_src = fetch_pkg::CF_INIT;
        end else if (is_resteer) begin
            cf_src = fetch_pkg::CF_RESTEER;
        end else if (is_br_taken) begin
            cf_src = fetch_pkg::CF_BRANCH;
        end else begin
            cf_src = fetch_pkg::CF_SEQ;
        end
    end

    always_comb begin
        unique case (cf_src)
            fetch_pkg::CF_INIT:    bip_d = init_bip;
            fetch_pkg::CF_RESTEER: bip_d = wb_bip;
            fetch_pkg::CF_BRANCH:  bip_d = bp_bip;
            default:               bip_d = new_bip;
        endcase
    end

    // redirects load even into a stalled or empty buffer
    assign adv_ok = ~stall & packet_out_valid;
    assign flush  = is_init | is_resteer;
    assign ld_bip = flush | adv_ok;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            old_bip <= '0;
        end else if (ld_bip) begin
            old_bip <= bip_d;
        end
    end

    //////////////////////////////////////////////////
    // line release on sequential advance
    //////////////////////////////////////////////////

    assign seq_ld      = adv_ok & (cf_src == fetch_pkg::CF_SEQ);
    assign free_strobe = seq_ld & (new_bip[5:4] != old_bip[5:4]);
    assign free_line   = old_bip[5:4];

endmodule

/* source/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// bytes held by one buffer line
`define FETCH_LINE_BYTES 16
`define FETCH_NUM_LINES  4

// one line as a single 128-bit word
`define FETCH_LINE_W     (`FETCH_LINE_BYTES * 8)

// byte pointer into the 64-byte window
`define FETCH_BIP_W      6
`define FETCH_LEN_W      8

// whole buffer seen as one flat window
`define FETCH_BUF_W      (`FETCH_NUM_LINES * `FETCH_LINE_W)

`endif

/* source/fetch_pkg.sv */
`include "fetch_macros.svh"

package fetch_pkg;

    //////////////////////////////////////////////////
    // buffer line
    //////////////////////////////////////////////////

    // byte k sits in bits 8k+7 down to 8k
    typedef logic [`FETCH_LINE_W-1:0] line_t;

    //////////////////////////////////////////////////
    // control-flow source of the next bip
    //////////////////////////////////////////////////

    // ordered by rising priority
    typedef enum logic [1:0] {
        CF_SEQ     = 2'd0,
        CF_BRANCH  = 2'd1,
        CF_RESTEER = 2'd2,
        CF_INIT    = 2'd3
    } cf_src_e;

endpackage

/* source/fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_macros.svh"

module fetch_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  fetch_pkg::line_t        fill_data,
    input  logic [1:0]              fill_line,
    input  logic                    fill_strobe,
    input  logic [`FETCH_LEN_W-1:0] d_length,
    input  logic                    stall,
    input  logic [`FETCH_BIP_W-1:0] wb_bip,
    input  logic                    is_resteer,
    input  logic [`FETCH_BIP_W-1:0] bp_bip,
    input  logic                    is_br_taken,
    input  logic [`FETCH_BIP_W-1:0] init_bip,
    input  logic                    is_init,
    output fetch_pkg::line_t        packet_out,
    output logic                    packet_out_valid,
    output logic [`FETCH_BIP_W-1:0] old_bip,
    output logic [`FETCH_BIP_W-1:0] new_bip
);

    logic                    flush;
    logic                    free_strobe;
    logic [1:0]              free_line;
    logic [`FETCH_BUF_W-1:0] window;

    //////////////////////////////////////////////////
    // bip register and next-bip select
    //////////////////////////////////////////////////

    fetch_bip u_bip (
        .clk              (clk),
        .arst_n           (arst_n),
        .d_length         (d_length),
        .stall            (stall),
        .is_resteer       (is_resteer),
        .is_br_taken      (is_br_taken),
        .is_init          (is_init),
        .packet_out_valid (packet_out_valid),
        .wb_bip           (wb_bip),
        .bp_bip           (bp_bip),
        .init_bip         (init_bip),
        .old_bip          (old_bip),
        .new_bip          (new_bip),
        .flush            (flush),
        .free_strobe      (free_strobe),
        .free_line        (free_line)
    );

    // four-line buffer
    ibuf_lines u_ibuf (
        .clk              (clk),
        .arst_n           (arst_n),
        .fill_data        (fill_data),
        .fill_line        (fill_line),
        .fill_strobe      (fill_strobe),
        .flush            (flush),
        .free_strobe      (free_strobe),
        .free_line        (free_line),
        .new_bip          (new_bip),
        .window           (window),
        .packet_out_valid (packet_out_valid)
    );

    // packet extraction
    packet_rotate u_rot (
        .window     (window),
        .new_bip    (new_bip),
        .packet_out (packet_out)
    );

endmodule

/* source/ibuf_lines.sv */
`timescale 1ns/1ns
`include "fetch_macros.svh"

module ibuf_lines (
    input  logic                     clk,
    input  logic                     arst_n,
    input  fetch_pkg::line_t         fill_data,
    input  logic [1:0]               fill_line,
    input  logic                     fill_strobe,
    input  logic                     flush,
    input  logic                     free_strobe,
    input  logic [1:0]               free_line,
    input  logic [`FETCH_BIP_W-1:0]  new_bip,
    output logic [`FETCH_BUF_W-1:0]  window,
    output logic                     packet_out_valid
);

    fetch_pkg::line_t             line_q [`FETCH_NUM_LINES];
    logic [`FETCH_NUM_LINES-1:0]  valid_q;
    logic                         fill_ok;
    logic [1:0]                   cur_line;
    logic [1:0]                   nxt_line;

    // fills only land in empty lines
    assign fill_ok = fill_strobe & ~valid_q[fill_line] & ~flush;

    //////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else begin
            if (free_strobe) begin
                valid_q[free_line] <= 1'b0;
            end
            // a fill of the freed line overrides the free
            if (fill_ok) begin
                valid_q[fill_line] <= 1'b1;
            end
        end
    end

    // line storage
    always_ff @(posedge clk) begin
        if (fill_ok) begin
            line_q[fill_line] <= fill_data;
        end
    end

    // line 0 holds window bytes 0 to 15
    assign window = {line_q[3], line_q[2], line_q[1], line_q[0]};

    //////////////////////////////////////////////////
    // window check under new_bip
    //////////////////////////////////////////////////

    // packet may straddle into the next line, which wraps 3 -> 0
    assign cur_line = new_bip[5:4];
    assign nxt_line = cur_line + 2'd1;

    assign packet_out_valid = valid_q[cur_line] & valid_q[nxt_line];

endmodule

/* source/packet_rotate.sv */
`timescale 1ns/1ns
`include "fetch_macros.svh"

module packet_rotate (
    input  logic [`FETCH_BUF_W-1:0] window,
    input  logic [`FETCH_BIP_W-1:0] new_bip,
    output fetch_pkg::line_t        packet_out
);

    // stage s+1 is stage s, optionally rotated right by 2**s bytes
    logic [`FETCH_BUF_W-1:0] stage [`FETCH_BIP_W+1];

    assign stage[0] = window;

    //////////////////////////////////////////////////
    // layered byte rotator
    //////////////////////////////////////////////////

    genvar s;
    generate
        for (s = 0; s < `FETCH_BIP_W; s = s + 1) begin : g_layer
            localparam int SH = 8 * (1 << s);
            logic [`FETCH_BUF_W-1:0] rot;

            // low bytes wrap around to the top
            assign rot = {stage[s][SH-1:0], stage[s][`FETCH_BUF_W-1:SH]};

            assign stage[s+1] = new_bip[s] ? rot : stage[s];
        end
    endgenerate

    // first 16 bytes from new_bip onward
    assign packet_out = stage[`FETCH_BIP_W][`FETCH_LINE_W-1:0];

endmodule

/* tb.f */
+incdir+source
source/fetch_pkg.sv
source/ibuf_lines.sv
source/fetch_bip.sv
source/packet_rotate.sv
source/fetch_top.sv
tb/fetch_checker.sv
tb/tb_fetch.sv

/* tb/fetch_checker.sv */
`timescale 1ns/1ns
`include "fetch_macros.svh"

module fetch_checker (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    is_init,
    input logic                    is_resteer,
    input logic                    stall,
    input logic                    flush,
    input logic                    packet_out_valid,
    input logic [`FETCH_BIP_W-1:0] init_bip,
    input logic [`FETCH_BIP_W-1:0] old_bip
);

    //////////////////////////////////////////////////
    // reset and redirects
    //////////////////////////////////////////////////

    // buffer starts out empty
    a_reset_empty: assert property (@(posedge clk) $rose(arst_n) |-> !packet_out_valid)
        else $error("packet valid in the first cycle after reset release");

    a_init_load: assert property (@(posedge clk) disable iff (!arst_n)
        is_init |=> old_bip == $past(init_bip))
        else $error("old_bip did not take init_bip");

    // only a redirect may move a stalled bip
    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stall && !is_init && !is_resteer |=> $stable(old_bip))
        else $error("old_bip moved under stall");

    a_flush_empty: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !packet_out_valid)
        else $error("packet valid right after a flush");

endmodule

/* tb/tb_fetch.sv */
`timescale 1ns/1ns
`include "fetch_macros.svh"

module tb_fetch;

    logic                    clk;
    logic                    arst_n;
    fetch_pkg::line_t        fill_data;
    logic [1:0]              fill_line;
    logic                    fill_strobe;
    logic [`FETCH_LEN_W-1:0] d_length;
    logic                    stall;
    logic [`FETCH_BIP_W-1:0] wb_bip;
    logic                    is_resteer;
    logic [`FETCH_BIP_W-1:0] bp_bip;
    logic                    is_br_taken;
    logic [`FETCH_BIP_W-1:0] init_bip;
    logic                    is_init;
    fetch_pkg::line_t        packet_out;
    logic                    packet_out_valid;
    logic [`FETCH_BIP_W-1:0] old_bip;
    logic [`FETCH_BIP_W-1:0] new_bip;

    // reference model state
    fetch_pkg::line_t m_line [`FETCH_NUM_LINES];
    logic [3:0]       m_valid;
    logic [5:0]       m_bip;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int test_err0;

    fetch_top dut0 (.*);

    bind fetch_top fetch_checker u_chk (
        .clk              (clk),
        .arst_n           (arst_n),
        .is_init          (is_init),
        .is_resteer       (is_resteer),
        .stall            (stall),
        .flush            (flush),
        .packet_out_valid (packet_out_valid),
        .init_bip         (init_bip),
        .old_bip          (old_bip)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // 16 bytes from start onward, wrapping past byte 63
    function automatic fetch_pkg::line_t model_packet(input logic [5:0] start);
        fetch_pkg::line_t p;
        logic [5:0]       idx;
        for (int k = 0; k < 16; k++) begin
            idx = start + 6'(k);
            p[8*k +: 8] = m_line[idx[5:4]][8*idx[3:0] +: 8];
        end
        return p;
    endfunction

    function automatic logic chance(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    task automatic expect_value(input string name, input string what,
                                input logic [127:0] exp, input logic [127:0] act);
        checks++;
        assert (exp === act) else begin
            $display("** Error %s: %s expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic drive_idle();
        fill_data   = '0;
        fill_line   = '0;
        fill_strobe = 1'b0;
        d_length    = '0;
        stall       = 1'b0;
        wb_bip      = '0;
        is_resteer  = 1'b0;
        bp_bip      = '0;
        is_br_taken = 1'b0;
        init_bip    = '0;
        is_init     = 1'b0;
    endtask

    task automatic drive_random(input int p_init, input int p_resteer, input int p_br,
                                input int p_stall, input int p_fill, input bit hold_on_stall);
        d_length    = 8'($urandom % 16);
        stall       = chance(p_stall);
        is_init     = chance(p_init);
        init_bip    = 6'($urandom);
        is_resteer  = chance(p_resteer);
        wb_bip      = 6'($urandom);
        is_br_taken = chance(p_br);
        bp_bip      = 6'($urandom);
        fill_strobe = chance(p_fill) & ~(hold_on_stall & stall);
        fill_line   = 2'($urandom);
        fill_data   = {$urandom, $urandom, $urandom, $urandom};
    endtask

    // compare outputs, then step the model over the coming edge
    task automatic check_cycle(input string name);
        fetch_pkg::cf_src_e src;
        logic [5:0]         exp_nb;
        logic [1:0]         cur;
        logic               exp_pv;
        logic               adv;
        logic               fill_ok;
        #1;
        exp_nb = 6'(m_bip + d_length);
        cur    = exp_nb[5:4];
        exp_pv = m_valid[cur] & m_valid[cur + 2'd1];
        expect_value(name, "old_bip", 128'(m_bip), 128'(old_bip));
        expect_value(name, "new_bip", 128'(exp_nb), 128'(new_bip));
        expect_value(name, "packet_out_valid", 128'(exp_pv), 128'(packet_out_valid));
        if (exp_pv) begin
            expect_value(name, "packet_out", model_packet(exp_nb), packet_out);
        end
        if (is_init) src = fetch_pkg::CF_INIT;
        else if (is_resteer) src = fetch_pkg::CF_RESTEER;
        else if (is_br_taken) src = fetch_pkg::CF_BRANCH;
        else src = fetch_pkg::CF_SEQ;
        adv     = ~stall & exp_pv;
        fill_ok = fill_strobe & ~m_valid[fill_line] & ~is_init & ~is_resteer;
        if (src == fetch_pkg::CF_INIT || src == fetch_pkg::CF_RESTEER) begin
            m_valid = '0;
        end else begin
            // left-behind line frees, a fill of the same line wins
            if (adv && src == fetch_pkg::CF_SEQ && cur != m_bip[5:4]) begin
                m_valid[m_bip[5:4]] = 1'b0;
            end
            if (fill_ok) begin
                m_valid[fill_line] = 1'b1;
                m_line[fill_line]  = fill_data;
            end
        end
        case (src)
            fetch_pkg::CF_INIT:    m_bip = init_bip;
            fetch_pkg::CF_RESTEER: m_bip = wb_bip;
            fetch_pkg::CF_BRANCH:  m_bip = adv ? bp_bip : m_bip;
            default:               m_bip = adv ? exp_nb : m_bip;
        endcase
    endtask

    //////////////////////////////////////////////////
    // test steps
    //////////////////////////////////////////////////

    task automatic redirect_init(input string name, input logic hold);
        @(negedge clk);
        drive_idle();
        stall    = hold;
        is_init  = 1'b1;
        init_bip = 6'($urandom);
        check_cycle(name);
    endtask

    // fill empty lines until the packet under the bip is complete
    task automatic wait_packet_valid(input string name, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            drive_idle();
            for (int i = 3; i >= 0; i--) begin
                if (!m_valid[i]) begin
                    fill_strobe = 1'b1;
                    fill_line   = 2'(i);
                    fill_data   = {$urandom, $urandom, $urandom, $urandom};
                end
            end
            check_cycle(name);
            n++;
        end while (!packet_out_valid && n < limit);
        if (!packet_out_valid) begin
            $display("%s: timed out after %0d cycles waiting for a valid packet", name, limit);
            errors++;
        end
    endtask

    task automatic run_random(input string name, input int cycles, input int p_init,
                              input int p_resteer, input int p_br, input int p_stall,
                              input int p_fill, input bit hold_on_stall);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            drive_random(p_init, p_resteer, p_br, p_stall, p_fill, hold_on_stall);
            check_cycle(name);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err0) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_err0    = 0;
        void'($urandom(15861));
        arst_n  = 1'b0;
        drive_idle();
        m_valid = '0;
        m_bip   = '0;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
        end
        arst_n = 1'b1;

        check_cycle("reset_init");
        for (int i = 0; i < 8; i++) begin
            redirect_init("reset_init", 1'b1);
            @(negedge clk);
            drive_idle();
            stall = 1'b1;
            check_cycle("reset_init");
        end
        finish_test("reset_init");

        redirect_init("fill_extract", 1'b0);
        wait_packet_valid("fill_extract", 20);
        run_random("fill_extract", 300, 0, 0, 0, 0, 80, 1'b0);
        finish_test("fill_extract");

        redirect_init("valid_free", 1'b0);
        wait_packet_valid("valid_free", 20);
        run_random("valid_free", 200, 0, 0, 0, 10, 30, 1'b0);
        finish_test("valid_free");

        run_random("cf_priority", 200, 10, 20, 40, 20, 70, 1'b0);
        finish_test("cf_priority");

        run_random("stall", 200, 5, 5, 30, 50, 60, 1'b1);
        finish_test("stall");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
